/* rtl/imuldiv_settings.svh */
// ------------------------------------------------
// operand width and iteration count of the muldiv unit
// the iteration count has to equal the operand width
// ------------------------------------------------
`ifndef IMULDIV_SETTINGS_SVH
`define IMULDIV_SETTINGS_SVH

// ------------------------------------------------
// datapath sizing
// ------------------------------------------------

// operand width in bits, responses are twice this
`define IMULDIV_XLEN 32

// one calculation cycle per operand bit
`define IMULDIV_ITERS 32

`endif

/* rtl/imuldiv_pkg.sv */
// ------------------------------------------------
// opcode and FSM state types for the muldiv unit
// ------------------------------------------------
package imuldiv_pkg;

  // ------------------------------------------------
  // opcodes
  // ------------------------------------------------

  // signed and unsigned flavours of each operation
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } muldiv_op_e;

  // ------------------------------------------------
  // iterative unit FSM
  // ------------------------------------------------

  // idle takes a request, calc runs one bit per cycle,
  // done holds the response until it is taken
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } iter_state_e;

endpackage

/* rtl/imuldiv_unit_if.sv */
// ------------------------------------------------
// request/response channel to one arithmetic unit
// one request in flight, valid/ready on both sides
// ------------------------------------------------
`include "imuldiv_settings.svh"

interface imuldiv_unit_if;

  // request payload
  logic [`IMULDIV_XLEN-1:0]   a;
  logic [`IMULDIV_XLEN-1:0]   b;
  logic                       is_signed;

  // request handshake
  logic                       req_val;
  logic                       req_rdy;

  // response payload, held while resp_val and not resp_rdy
  logic [2*`IMULDIV_XLEN-1:0] result;

  // response handshake
  logic                       resp_val;
  logic                       resp_rdy;

  // top level side
  modport master (
    output a, b, is_signed, req_val, resp_rdy,
    input  req_rdy, result, resp_val
  );

  // arithmetic unit side
  modport unit (
    input  a, b, is_signed, req_val, resp_rdy,
    output req_rdy, result, resp_val
  );

endinterface

/* rtl/imuldiv_mul_iterative.sv */
// ------------------------------------------------
// iterative shift-and-add multiplier, 64-bit product
// fixed 32 calc cycles, no early exit on small operands
// ------------------------------------------------
`include "imuldiv_settings.svh"

module imuldiv_mul_iterative (
  input logic          clk,
  input logic          reset,
  imuldiv_unit_if.unit port
);

  logic load;
  logic shift;
  logic b_lsb;

  // registers, adder and sign fix
  imuldiv_mul_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .a         (port.a),
    .b         (port.b),
    .is_signed (port.is_signed),
    .load      (load),
    .shift     (shift),
    .b_lsb     (b_lsb),
    .result    (port.result)
  );

  // sequencing and handshake
  imuldiv_mul_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (port.req_val),
    .resp_rdy (port.resp_rdy),
    .req_rdy  (port.req_rdy),
    .resp_val (port.resp_val),
    .load     (load),
    .shift    (shift)
  );

  // multiplier register is fully consumed once the FSM reports done
  a_mplier_drained: assert property (@(posedge clk) disable iff (reset)
    port.resp_val |-> !b_lsb);

endmodule

// ------------------------------------------------
// datapath
// ------------------------------------------------
module imuldiv_mul_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`IMULDIV_XLEN-1:0]   a,
  input  logic [`IMULDIV_XLEN-1:0]   b,
  input  logic                       is_signed,
  input  logic                       load,
  input  logic                       shift,
  output logic                       b_lsb,
  output logic [2*`IMULDIV_XLEN-1:0] result
);

  localparam int XLEN = `IMULDIV_XLEN;

  logic [2*XLEN-1:0] mcand_reg;
  logic [XLEN-1:0]   mplier_reg;
  logic [2*XLEN-1:0] acc_reg;
  logic              neg_reg;

  logic              a_neg;
  logic              b_neg;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;

  // operand signs only count for signed opcodes
  assign a_neg = is_signed && a[XLEN-1];
  assign b_neg = is_signed && b[XLEN-1];

  // magnitudes, most negative value maps to 2**31 unsigned
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  // product sign
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_reg <= 1'b0;
    end else if (load) begin
      neg_reg <= a_neg ^ b_neg;
    end
  end

  // multiplicand moves left, multiplier moves right
  always_ff @(posedge clk) begin
    if (load) begin
      mcand_reg  <= {{XLEN{1'b0}}, a_mag};
      mplier_reg <= b_mag;
      acc_reg    <= '0;
    end else if (shift) begin
      // add only when the current multiplier bit is set
      if (mplier_reg[0]) begin
        acc_reg <= acc_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  assign b_lsb = mplier_reg[0];

  // sign fix on the way out
  assign result = neg_reg ? (~acc_reg + 1'b1) : acc_reg;

endmodule

// ------------------------------------------------
// control
// ------------------------------------------------
module imuldiv_mul_ctrl
  import imuldiv_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic load,
  output logic shift
);

  // one spare bit so an overrun would be visible
  localparam int CNT_W = $clog2(`IMULDIV_ITERS + 1);

  iter_state_e      state;
  logic [CNT_W-1:0] count;
  logic             last_iter;

  assign last_iter = (count == CNT_W'(`IMULDIV_ITERS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_val) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // last shift happens on the exit edge
          if (last_iter) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          if (resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_comb begin
    req_rdy  = (state == st_idle);
    resp_val = (state == st_done);
    load     = req_rdy && req_val;
    shift    = (state == st_calc);
  end

  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val));

  a_count_range: assert property (@(posedge clk) disable iff (reset)
    (state == st_calc) |-> (count <= CNT_W'(`IMULDIV_ITERS - 1)));

endmodule

/* rtl/imuldiv_div_iterative.sv */
// ------------------------------------------------
// iterative restoring divider, {remainder, quotient}
// divide by zero gives quotient magnitude all ones
// ------------------------------------------------
`include "imuldiv_settings.svh"

module imuldiv_div_iterative (
  input logic          clk,
  input logic          reset,
  imuldiv_unit_if.unit port
);

  logic load;
  logic step;

  // remainder/quotient registers and subtractor
  imuldiv_div_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .a         (port.a),
    .b         (port.b),
    .is_signed (port.is_signed),
    .load      (load),
    .step      (step),
    .result    (port.result)
  );

  // sequencing and handshake
  imuldiv_div_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (port.req_val),
    .resp_rdy (port.resp_rdy),
    .req_rdy  (port.req_rdy),
    .resp_val (port.resp_val),
    .load     (load),
    .step     (step)
  );

  // response payload must hold under back-pressure
  a_result_hold: assert property (@(posedge clk) disable iff (reset)
    (port.resp_val && !port.resp_rdy) |=> $stable(port.result));

endmodule

// ------------------------------------------------
// datapath
// ------------------------------------------------
module imuldiv_div_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`IMULDIV_XLEN-1:0]   a,
  input  logic [`IMULDIV_XLEN-1:0]   b,
  input  logic                       is_signed,
  input  logic                       load,
  input  logic                       step,
  output logic [2*`IMULDIV_XLEN-1:0] result
);

  localparam int XLEN = `IMULDIV_XLEN;

  // starts as dividend magnitude, fills with quotient bits
  logic [XLEN-1:0] quot_reg;
  logic [XLEN-1:0] rem_reg;
  logic [XLEN-1:0] dvsr_reg;
  logic            q_neg_reg;
  logic            r_neg_reg;

  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic [XLEN:0]   rem_shift;
  logic [XLEN+1:0] diff;
  logic            fits;
  logic [XLEN-1:0] quot_fix;
  logic [XLEN-1:0] rem_fix;

  assign a_neg = is_signed && a[XLEN-1];
  assign b_neg = is_signed && b[XLEN-1];
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  // next dividend bit enters the partial remainder
  assign rem_shift = {rem_reg, quot_reg[XLEN-1]};

  // trial subtract, top bit set means it went negative
  assign diff = {1'b0, rem_shift} - {2'b00, dvsr_reg};
  assign fits = !diff[XLEN+1];

  // quotient sign from both operands, remainder follows the dividend
  always_ff @(posedge clk) begin
    if (reset) begin
      q_neg_reg <= 1'b0;
      r_neg_reg <= 1'b0;
    end else if (load) begin
      q_neg_reg <= a_neg ^ b_neg;
      r_neg_reg <= a_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      quot_reg <= a_mag;
      rem_reg  <= '0;
      dvsr_reg <= b_mag;
    end else if (step) begin
      // restore by keeping the shifted value when the subtract fails
      rem_reg  <= fits ? diff[XLEN-1:0] : rem_shift[XLEN-1:0];
      quot_reg <= {quot_reg[XLEN-2:0], fits};
    end
  end

  // sign fix, remainder in the upper half
  assign quot_fix = q_neg_reg ? (~quot_reg + 1'b1) : quot_reg;
  assign rem_fix  = r_neg_reg ? (~rem_reg + 1'b1) : rem_reg;
  assign result   = {rem_fix, quot_fix};

endmodule

// ------------------------------------------------
// control
// ------------------------------------------------
module imuldiv_div_ctrl
  import imuldiv_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic load,
  output logic step
);

  localparam int CNT_W = $clog2(`IMULDIV_ITERS);

  iter_state_e      state;
  // steps left after the current one
  logic [CNT_W-1:0] remaining;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      remaining <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_val) begin
            state     <= st_calc;
            remaining <= CNT_W'(`IMULDIV_ITERS - 1);
          end
        end
        st_calc: begin
          if (remaining == '0) begin
            state <= st_done;
          end else begin
            remaining <= remaining - 1'b1;
          end
        end
        st_done: begin
          // hold the result until the response transfers
          if (resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_comb begin
    req_rdy  = (state == st_idle);
    resp_val = (state == st_done);
    load     = req_rdy && req_val;
    step     = (state == st_calc);
  end

endmodule

/* rtl/imuldiv_muldiv_iterative.sv */
// ------------------------------------------------
// muldiv top level, one operation in flight at a time
// no cycles added on top of the unit latency
// ------------------------------------------------
`include "imuldiv_settings.svh"

module imuldiv_muldiv_iterative
  import imuldiv_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`IMULDIV_XLEN-1:0]   req_a,
  input  logic [`IMULDIV_XLEN-1:0]   req_b,
  input  muldiv_op_e                 req_op,
  input  logic                       req_val,
  output logic                       req_rdy,
  output logic [2*`IMULDIV_XLEN-1:0] resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  imuldiv_unit_if mul_if ();
  imuldiv_unit_if div_if ();

  logic busy_reg;
  // owner of the operation in flight, 1 for the divider
  logic owner_div_reg;
  logic op_is_div;
  logic op_is_signed;
  logic req_fire;
  logic resp_fire;

  // ------------------------------------------------
  // opcode decode and dispatch
  // ------------------------------------------------
  assign op_is_div    = (req_op == op_div) || (req_op == op_divu);
  assign op_is_signed = (req_op == op_mul) || (req_op == op_div);

  // both units see the operands, only one gets req_val
  assign mul_if.a         = req_a;
  assign mul_if.b         = req_b;
  assign mul_if.is_signed = op_is_signed;
  assign mul_if.req_val   = req_val && !busy_reg && !op_is_div;

  assign div_if.a         = req_a;
  assign div_if.b         = req_b;
  assign div_if.is_signed = op_is_signed;
  assign div_if.req_val   = req_val && !busy_reg && op_is_div;

  // ------------------------------------------------
  // response return
  // ------------------------------------------------
  assign mul_if.resp_rdy = resp_rdy && busy_reg && !owner_div_reg;
  assign div_if.resp_rdy = resp_rdy && busy_reg && owner_div_reg;

  assign req_rdy     = !busy_reg && mul_if.req_rdy && div_if.req_rdy;
  assign resp_val    = busy_reg && (owner_div_reg ? div_if.resp_val : mul_if.resp_val);
  assign resp_result = owner_div_reg ? div_if.result : mul_if.result;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // busy from the accepting edge to the response transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_reg      <= 1'b0;
      owner_div_reg <= 1'b0;
    end else if (req_fire) begin
      busy_reg      <= 1'b1;
      owner_div_reg <= op_is_div;
    end else if (resp_fire) begin
      busy_reg <= 1'b0;
    end
  end

  // ------------------------------------------------
  // units
  // ------------------------------------------------
  imuldiv_mul_iterative mul_unit (
    .clk   (clk),
    .reset (reset),
    .port  (mul_if.unit)
  );

  imuldiv_div_iterative div_unit (
    .clk   (clk),
    .reset (reset),
    .port  (div_if.unit)
  );

  // a unit may only respond for the operation it owns
  a_mul_owner: assert property (@(posedge clk) disable iff (reset)
    mul_if.resp_val |-> (busy_reg && !owner_div_reg));

  a_div_owner: assert property (@(posedge clk) disable iff (reset)
    div_if.resp_val |-> (busy_reg && owner_div_reg));

endmodule

/* sim/imuldiv_tb.sv */
// ------------------------------------------------
// testbench for the iterative muldiv top level
// one request in flight at a time
// LCG stimulus with seed 14
// ------------------------------------------------
`include "imuldiv_settings.svh"

module imuldiv_tb
  import imuldiv_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int xlen = `IMULDIV_XLEN;
  // request counts per phase
  localparam int n_dir = 8;
  localparam int n_random = 200;
  localparam int n_stall = 40;
  localparam int max_stall = 7;
  localparam int num_req = 2 * n_dir + 2 * n_dir + n_random + n_stall;
  localparam int timeout_cycles = num_req * (34 + max_stall) + 100;
  // accept edge to the first edge that samples resp_val high
  localparam int resp_edges = `IMULDIV_ITERS + 1;

  // directed multiply corners
  localparam logic [xlen-1:0] mul_a [n_dir] = '{32'h0, 32'h1, 32'hffffffff,
    32'hffffffff, 32'h80000000, 32'h80000000, 32'hfffffffd, 32'h7};
  localparam logic [xlen-1:0] mul_b [n_dir] = '{32'h5, 32'h1234, 32'hffffffff,
    32'h7, 32'h80000000, 32'hffffffff, 32'h5, 32'hfffffff7};
  // directed divide corners with the zero divisors first
  localparam logic [xlen-1:0] div_a [n_dir] = '{32'h64, 32'hffffff9c, 32'h80000000,
    32'hfffffff9, 32'hffffff9c, 32'h3039, 32'hfffffffb, 32'h7};
  localparam logic [xlen-1:0] div_b [n_dir] = '{32'h0, 32'h0, 32'hffffffff,
    32'h2, 32'h7, 32'h3039, 32'hfffffffb, 32'hfffffffe};

  logic              clk = 1'b0;
  logic              reset;
  logic [xlen-1:0]   req_a;
  logic [xlen-1:0]   req_b;
  muldiv_op_e        req_op;
  logic              req_val;
  logic              req_rdy;
  logic [2*xlen-1:0] resp_result;
  logic              resp_val;
  logic              resp_rdy;

  logic [31:0]       rand_state = 32'd14;
  logic [2*xlen-1:0] expect_q [$];
  logic [2*xlen-1:0] held_result;
  logic              stalled_prev = 1'b0;
  logic              resp_seen = 1'b0;
  int                cycle = 0;
  int                accept_edge = 0;
  int                issued = 0;
  int                resp_count = 0;

  imuldiv_muldiv_iterative uut (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_op      (req_op),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // expected response from magnitudes and sign rules
  function automatic logic [2*xlen-1:0] ref_result(input muldiv_op_e op,
                                                   input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b);
    logic              sgn;
    logic              a_neg;
    logic              b_neg;
    logic [xlen-1:0]   a_mag;
    logic [xlen-1:0]   b_mag;
    logic [2*xlen-1:0] prod;
    logic [xlen-1:0]   quot;
    logic [xlen-1:0]   rem;
    sgn   = (op == op_mul) || (op == op_div);
    a_neg = sgn && a[xlen-1];
    b_neg = sgn && b[xlen-1];
    a_mag = a_neg ? -a : a;
    b_mag = b_neg ? -b : b;
    if (op == op_mul || op == op_mulu) begin
      prod = {{xlen{1'b0}}, a_mag} * {{xlen{1'b0}}, b_mag};
      return (a_neg ^ b_neg) ? -prod : prod;
    end
    // a zero divisor gives an all ones quotient and the dividend as remainder
    if (b_mag == '0) begin
      quot = '1;
      rem  = a_mag;
    end else begin
      quot = a_mag / b_mag;
      rem  = a_mag % b_mag;
    end
    if (a_neg ^ b_neg) quot = -quot;
    if (a_neg) rem = -rem;
    return {rem, quot};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [2*xlen-1:0] got,
                                 input logic [2*xlen-1:0] exp);
    $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    abort_run("value mismatch at the DUT outputs");
  endtask

  // called just after a rising edge and returns on the response edge
  task automatic run_op(input muldiv_op_e op, input logic [xlen-1:0] a,
                        input logic [xlen-1:0] b, input int stall);
    #0.5;
    req_op   = op;
    req_a    = a;
    req_b    = b;
    req_val  = 1'b1;
    resp_rdy = (stall == 0);
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    @(posedge clk);
    #0.5;
    // keep offering under back-pressure since the DUT must not take it
    req_val = (stall != 0);
    @(negedge clk);
    while (!resp_val) @(negedge clk);
    if (stall != 0) begin
      repeat (stall) @(posedge clk);
      #0.5;
      resp_rdy = 1'b1;
      req_val  = 1'b0;
    end
    @(posedge clk);
    issued++;
  endtask

  // ------------------------------------------------
  // cycle count and timeout
  // ------------------------------------------------
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      abort_run("timeout: the DUT stopped answering requests");
    end
  end

  // ------------------------------------------------
  // compare process on the falling edge
  // ------------------------------------------------
  always @(negedge clk) begin
    if (!reset) begin
      // ready only while nothing is in flight
      assert (req_rdy === (expect_q.size() == 0))
        else report_mismatch("req_rdy", 64'(req_rdy), 64'(expect_q.size() == 0));
      if (expect_q.size() == 0) begin
        assert (resp_val === 1'b0)
          else abort_run("response raised with no request pending");
      end
      if (resp_val && !resp_seen) begin
        resp_seen = 1'b1;
        assert (cycle + 1 - accept_edge == resp_edges)
          else report_mismatch("resp_val latency", 64'(cycle + 1 - accept_edge),
                               64'(resp_edges));
      end
      // valid and payload must hold across a stalled edge
      if (stalled_prev) begin
        assert (resp_val === 1'b1)
          else abort_run("resp_val dropped before the response transferred");
        assert (resp_result === held_result)
          else report_mismatch("resp_result (held)", resp_result, held_result);
      end
      if (resp_val && resp_rdy) begin
        assert (resp_result === expect_q[0])
          else report_mismatch("resp_result", resp_result, expect_q[0]);
        void'(expect_q.pop_front());
        resp_count++;
        resp_seen    = 1'b0;
        stalled_prev = 1'b0;
      end else if (resp_val) begin
        stalled_prev = 1'b1;
        held_result  = resp_result;
      end
      if (req_val && req_rdy) begin
        expect_q.push_back(ref_result(req_op, req_a, req_b));
        accept_edge = cycle + 1;
      end
    end
  end

  // ------------------------------------------------
  // stimulus
  // ------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    reset    = 1'b1;
    req_a    = '0;
    req_b    = '0;
    req_op   = op_mul;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (3) @(posedge clk);
    #0.5;
    reset = 1'b0;
    @(negedge clk);
    assert (req_rdy === 1'b1 && resp_val === 1'b0)
      else abort_run("DUT not idle after reset");
    @(posedge clk);
    for (int i = 0; i < n_dir; i++) begin
      run_op(op_mul, mul_a[i], mul_b[i], 0);
      run_op(op_mulu, mul_a[i], mul_b[i], 0);
    end
    for (int i = 0; i < n_dir; i++) begin
      run_op(op_div, div_a[i], div_b[i], 0);
      run_op(op_divu, div_a[i], div_b[i], 0);
    end
    // random mix with resp_rdy held high
    for (int i = 0; i < n_random; i++) begin
      r = next_rand();
      a = next_rand();
      b = next_rand();
      // narrow divisors now and then for larger quotients
      if (r[29]) b = b >> r[4:0];
      run_op(muldiv_op_e'(r[31:30]), a, b, 0);
    end
    // back-pressure with 0 to 7 stalled cycles
    for (int i = 0; i < n_stall; i++) begin
      r = next_rand();
      a = next_rand();
      b = next_rand() >> r[4:0];
      run_op(muldiv_op_e'(r[31:30]), a, b, int'(r[27:25]));
    end
    repeat (4) @(negedge clk);
    if (resp_count == issued && expect_q.size() == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run("responses lost or duplicated at the end of the run");
    end
  end

endmodule

/* project.f */
+incdir+rtl
rtl/imuldiv_pkg.sv
rtl/imuldiv_unit_if.sv
rtl/imuldiv_mul_iterative.sv
rtl/imuldiv_div_iterative.sv
rtl/imuldiv_muldiv_iterative.sv
sim/imuldiv_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the muldiv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module imuldiv_tb -f project.f \
  --Mdir obj_dir -o imuldiv_sim

# the pipeline status is the one of tee, the log decides
./obj_dir/imuldiv_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "run ended without a result, see sim.log"
  exit 1
fi
exit 0
